// ==== all.f ====
+incdir+rtl
rtl/lane_pkg.sv
rtl/operand_if.sv
rtl/issue_fsm.sv
rtl/slice_counter.sv
rtl/lane_regfile.sv
rtl/bypass_buff.sv
rtl/network_s.sv
rtl/lane_alu.sv
rtl/lane_top.sv
sim/lane_properties.sv
sim/tb_lane.sv

// ==== rtl/bypass_buff.sv ====
// Bypass write buffer
// Ordered queue of index/data pairs, newest-match forwarding, drain
`timescale 1ns/1ps

module bypass_buff
	import lane_pkg::*;
`include "lane_params.svh"
#(
	parameter int BUFF_SIZE = `LANE_BUFF_SIZE
)(
	input  logic   clock,
	input  logic   arst_n,
	input  logic   stall,
	input  logic   wb_valid,
	input  index_t wb_index,
	input  data_t  wb_data,
	input  index_t idx1,
	input  index_t idx2,
	input  index_t idx3,
	input  data_t  src1,
	input  data_t  src2,
	input  data_t  src3,
	output data_t  out1,
	output data_t  out2,
	output data_t  out3,
	input  logic   drain_ready,
	output logic   drain_valid,
	output index_t drain_index,
	output data_t  drain_data,
	output logic   full
);

	localparam int CNT_W = $clog2(BUFF_SIZE + 1);
	// Two writebacks may still be in flight after issue stops
	localparam logic [CNT_W-1:0] FULL_AT = (BUFF_SIZE > 2) ? CNT_W'(BUFF_SIZE - 2) : CNT_W'(1);

	index_t           ent_idx  [BUFF_SIZE];   // Slot 0 is oldest
	data_t            ent_data [BUFF_SIZE];
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nx;
	logic [CNT_W-1:0] wr_pos;
	logic             pop;
	index_t           q_idx [3];
	data_t            q_src [3];
	data_t            q_out [3];

	assign pop         = drain_ready && (count != '0);
	assign drain_valid = (count != '0);
	assign drain_index = ent_idx[0];
	assign drain_data  = ent_data[0];
	assign wr_pos      = count - CNT_W'(pop);                 // Slot after the shift
	assign count_nx    = count + CNT_W'(wb_valid) - CNT_W'(pop);

	////////////////////////////////////////////////////////////
	// Queue slots, shift down on drain
	for (genvar k = 0; k < BUFF_SIZE; k++) begin : g_slot
		index_t up_idx;
		data_t  up_data;

		if (k < BUFF_SIZE - 1) begin : g_mid
			assign up_idx  = ent_idx[k+1];
			assign up_data = ent_data[k+1];
		end else begin : g_top
			assign up_idx  = ent_idx[k];
			assign up_data = ent_data[k];
		end

		always_ff @(posedge clock) begin
			if (wb_valid && (wr_pos == CNT_W'(k))) begin
				ent_idx[k]  <= wb_index;
				ent_data[k] <= wb_data;
			end else if (pop) begin
				ent_idx[k]  <= up_idx;
				ent_data[k] <= up_data;
			end
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			full  <= 1'b0;
		end else begin
			count <= count_nx;
			// Once stalled, hold full until the queue is empty
			full  <= (count_nx >= FULL_AT) || (stall && (count_nx != '0));
		end
	end

	////////////////////////////////////////////////////////////
	// Forwarding, later slots are newer and win
	assign q_idx[0] = idx1;
	assign q_idx[1] = idx2;
	assign q_idx[2] = idx3;
	assign q_src[0] = src1;
	assign q_src[1] = src2;
	assign q_src[2] = src3;

	always_comb begin
		for (int s = 0; s < 3; s++) begin
			q_out[s] = q_src[s];                              // Regfile data by default
			for (int k = 0; k < BUFF_SIZE; k++) begin
				if ((CNT_W'(k) < count) && (ent_idx[k] == q_idx[s])) begin
					q_out[s] = ent_data[k];
				end
			end
		end
	end

	assign out1 = q_out[0];
	assign out2 = q_out[1];
	assign out3 = q_out[2];

endmodule

// ==== rtl/issue_fsm.sv ====
// Issue FSM for one vector instruction
// Start, stall on full buffer, drain countdown and done pulse
`timescale 1ns/1ps

module issue_fsm
	import lane_pkg::*;
(
	input  logic   clock,
	input  logic   arst_n,
	input  logic   start,
	input  index_t slice_len,
	input  logic   stall,         // Bypass buffer full
	input  logic   last,          // Counter on final element
	output logic   cnt_en,
	output logic   cnt_clr,
	output logic   req,           // Read data valid next cycle
	output logic   busy,
	output logic   done
);

	localparam logic [1:0] PIPE_DEPTH = 2'd2;     // Read stage plus ALU stage

	issue_state_t state;
	issue_state_t state_nx;
	logic [1:0]   drain_cnt;

	assign cnt_clr = (state == IDLE) && start;
	assign cnt_en  = (state == RUN) && !stall;    // One read launched
	assign busy    = (state != IDLE);

	always_comb begin
		state_nx = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nx = (slice_len == '0) ? DRAIN : RUN;    // Empty slice skips issue
				end
			end
			RUN: begin
				if (stall) begin
					state_nx = STALL;
				end else if (last) begin
					state_nx = DRAIN;                              // Final read goes out now
				end
			end
			STALL: begin
				if (!stall) begin
					state_nx = RUN;
				end
			end
			DRAIN: begin
				if (drain_cnt == 2'd1) begin
					state_nx = IDLE;
				end
			end
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			req       <= 1'b0;
			done      <= 1'b0;
			drain_cnt <= '0;
		end else begin
			state <= state_nx;
			req   <= cnt_en;                                       // Aligns with registered read
			done  <= (state == DRAIN) && (drain_cnt == 2'd1);
			if ((state_nx == DRAIN) && (state != DRAIN)) begin
				drain_cnt <= PIPE_DEPTH;
			end else if (drain_cnt != '0) begin
				drain_cnt <= drain_cnt - 2'd1;
			end
		end
	end

endmodule

// ==== rtl/lane_alu.sv ====
// Registered lane ALU over three operands
// ADD, SUB, MAC, PASS with index and valid carried along
`timescale 1ns/1ps

module lane_alu
	import lane_pkg::*;
(
	input  logic    clock,
	input  logic    arst_n,
	input  logic    en,              // Operands valid
	input  alu_op_t op,
	input  index_t  dst_index,
	input  data_t   a,
	input  data_t   b,
	input  data_t   c,
	output logic    res_valid,
	output index_t  res_index,
	output data_t   res
);

	data_t res_nx;

	always_comb begin
		case (op)
			ADD:     res_nx = a + b;
			SUB:     res_nx = a - b;
			MAC:     res_nx = a * b + c;        // Low word only
			default: res_nx = a;
		endcase
	end

	always_ff @(posedge clock) begin
		if (en) begin
			res       <= res_nx;
			res_index <= dst_index;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= en;
		end
	end

endmodule

// ==== rtl/lane_params.svh ====
// Lane size and depth defines
// Data width, register count, bypass depth, slice limit
`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// Datapath word width
`define LANE_DATA_W 32

`define LANE_NUM_REGS 64         // Register file entries

`define LANE_BUFF_SIZE 4         // Bypass buffer entries

`define LANE_SLICE_MAX 32        // Longest slice one instruction runs

`endif

// ==== rtl/lane_pkg.sv ====
// Lane types
// Word and index vectors, path select, ALU ops, issue states
package lane_pkg;

`include "lane_params.svh"

	typedef logic [`LANE_DATA_W-1:0] data_t;                   // One data word
	typedef logic [$clog2(`LANE_NUM_REGS)-1:0] index_t;        // Reg index, slice length
	typedef logic [1:0] sel_path_t;                            // 0 none or ALU, 1..3 source

	typedef enum logic [1:0] {
		ADD  = 2'd0,     // s1 + s2
		SUB  = 2'd1,     // s1 - s2
		MAC  = 2'd2,     // Low word of s1*s2 + s3
		PASS = 2'd3      // s1
	} alu_op_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,    // One element read per cycle
		STALL = 2'd2,    // Buffer full, issue held
		DRAIN = 2'd3     // Wait for pipeline to empty
	} issue_state_t;

endpackage

// ==== rtl/lane_regfile.sv ====
// Lane register file, three registered reads and one shared write
// Write port arbitration between load port and buffer drain
`timescale 1ns/1ps

module lane_regfile
	import lane_pkg::*;
`include "lane_params.svh"
(
	input  logic      clock,
	input  logic      arst_n,
	operand_if.reader ops,
	input  index_t    base1,
	input  index_t    base2,
	input  index_t    base3,
	input  index_t    index,           // Current element
	input  index_t    dst_base,
	output index_t    dst_index,       // Destination of element on ops
	input  logic      ld_valid,
	input  index_t    ld_index,
	input  data_t     ld_data,
	input  logic      drain_valid,
	input  index_t    drain_index,
	input  data_t     drain_data,
	output logic      drain_ready
);

	data_t  mem [`LANE_NUM_REGS];
	index_t raddr [3];
	index_t idx_q [3];
	data_t  rdata_q [3];
	logic   we;
	index_t waddr;
	data_t  wdata;

	assign raddr[0] = base1 + index;
	assign raddr[1] = base2 + index;
	assign raddr[2] = base3 + index;

	////////////////////////////////////////////////////////////
	// Write port
	assign drain_ready = !ld_valid;                       // Load wins
	assign we          = ld_valid || drain_valid;
	assign waddr       = ld_valid ? ld_index : drain_index;
	assign wdata       = ld_valid ? ld_data : drain_data;

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	always_ff @(posedge clock) begin
		for (int i = 0; i < 3; i++) begin
			// Same-cycle write seen by the read
			rdata_q[i] <= (we && (waddr == raddr[i])) ? wdata : mem[raddr[i]];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 3; i++) begin
				idx_q[i] <= '0;
			end
			dst_index <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				idx_q[i] <= raddr[i];             // Index travels with its data
			end
			dst_index <= dst_base + index;
		end
	end

	assign ops.idx1 = idx_q[0];
	assign ops.idx2 = idx_q[1];
	assign ops.idx3 = idx_q[2];
	assign ops.src1 = rdata_q[0];
	assign ops.src2 = rdata_q[1];
	assign ops.src3 = rdata_q[2];

endmodule

// ==== rtl/lane_top.sv ====
// Vector lane operand path top level
// Issue FSM, counter, regfile, routing network, ALU
`timescale 1ns/1ps

module lane_top
	import lane_pkg::*;
(
	input  logic       clock,
	input  logic       arst_n,
	input  logic       start,
	input  alu_op_t    op,
	input  index_t     dst,
	input  index_t     src1_base,
	input  index_t     src2_base,
	input  index_t     src3_base,
	input  index_t     slice_len,
	input  sel_path_t  sel_path,
	input  sel_path_t  sel_path_wb,
	input  logic [2:0] sel_alu_src,
	input  logic       ld_valid,
	input  index_t     ld_index,
	input  data_t      ld_data,
	output logic       busy,
	output logic       done,
	output logic       wb_valid,
	output index_t     wb_index,
	output data_t      wb_data,
	output data_t      pac_data,
	output logic       buff_full
);

	operand_if ops ();

	logic   cnt_en;
	logic   cnt_clr;
	logic   last;
	index_t elem_index;
	index_t alu_dst;
	data_t  alu_a;
	data_t  alu_b;
	data_t  alu_c;
	data_t  alu_res;
	logic   drain_ready;
	logic   drain_valid;
	index_t drain_index;
	data_t  drain_data;

	issue_fsm u_issue_fsm (
		.clock     (clock),
		.arst_n    (arst_n),
		.start     (start),
		.slice_len (slice_len),
		.stall     (buff_full),
		.last      (last),
		.cnt_en    (cnt_en),
		.cnt_clr   (cnt_clr),
		.req       (ops.req),
		.busy      (busy),
		.done      (done)
	);

	slice_counter u_slice_counter (
		.clock     (clock),
		.arst_n    (arst_n),
		.clr       (cnt_clr),
		.en        (cnt_en),
		.slice_len (slice_len),
		.index     (elem_index),
		.last      (last)
	);

	lane_regfile u_lane_regfile (
		.clock       (clock),
		.arst_n      (arst_n),
		.ops         (ops),
		.base1       (src1_base),
		.base2       (src2_base),
		.base3       (src3_base),
		.index       (elem_index),
		.dst_base    (dst),
		.dst_index   (alu_dst),
		.ld_valid    (ld_valid),
		.ld_index    (ld_index),
		.ld_data     (ld_data),
		.drain_valid (drain_valid),
		.drain_index (drain_index),
		.drain_data  (drain_data),
		.drain_ready (drain_ready)
	);

	network_s u_network_s (
		.clock       (clock),
		.arst_n      (arst_n),
		.stall       (buff_full),
		.ops         (ops),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (alu_res),
		.sel_path    (sel_path),
		.sel_path_wb (sel_path_wb),
		.sel_alu_src (sel_alu_src),
		.src_data1   (alu_a),
		.src_data2   (alu_b),
		.src_data3   (alu_c),
		.pac_data    (pac_data),
		.wb_sel_data (wb_data),
		.buff_full   (buff_full),
		.drain_ready (drain_ready),
		.drain_valid (drain_valid),
		.drain_index (drain_index),
		.drain_data  (drain_data)
	);

	lane_alu u_lane_alu (
		.clock     (clock),
		.arst_n    (arst_n),
		.en        (ops.req),
		.op        (op),
		.dst_index (alu_dst),
		.a         (alu_a),
		.b         (alu_b),
		.c         (alu_c),
		.res_valid (wb_valid),
		.res_index (wb_index),
		.res       (alu_res)
	);

endmodule

// ==== rtl/network_s.sv ====
// Operand routing network
// PAC source gating, writeback path choice, bypass buffer
`timescale 1ns/1ps

module network_s
	import lane_pkg::*;
`include "lane_params.svh"
(
	input  logic       clock,
	input  logic       arst_n,
	input  logic       stall,
	operand_if.network ops,
	input  logic       wb_valid,          // ALU result valid
	input  index_t     wb_index,
	input  data_t      wb_data,
	input  sel_path_t  sel_path,          // PAC source
	input  sel_path_t  sel_path_wb,       // Writeback source, 0 is ALU
	input  logic [2:0] sel_alu_src,
	output data_t      src_data1,         // Forwarded operands to ALU
	output data_t      src_data2,
	output data_t      src_data3,
	output data_t      pac_data,
	output data_t      wb_sel_data,       // Word entering the buffer
	output logic       buff_full,
	input  logic       drain_ready,
	output logic       drain_valid,
	output index_t     drain_index,
	output data_t      drain_data
);

	data_t fwd [3];
	data_t pac_sel;
	data_t wb_src_sel;
	data_t pac_q;
	data_t wb_src_q;
	logic  use_src_q;

	bypass_buff #(
		.BUFF_SIZE   (`LANE_BUFF_SIZE)
	) u_bypass_buff (
		.clock       (clock),
		.arst_n      (arst_n),
		.stall       (stall),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (wb_sel_data),
		.idx1        (ops.idx1),
		.idx2        (ops.idx2),
		.idx3        (ops.idx3),
		.src1        (ops.src1),
		.src2        (ops.src2),
		.src3        (ops.src3),
		.out1        (fwd[0]),
		.out2        (fwd[1]),
		.out3        (fwd[2]),
		.drain_ready (drain_ready),
		.drain_valid (drain_valid),
		.drain_index (drain_index),
		.drain_data  (drain_data),
		.full        (buff_full)
	);

	assign src_data1 = fwd[0];
	assign src_data2 = fwd[1];
	assign src_data3 = fwd[2];

	// Source reaches PAC only when path and ALU select agree
	always_comb begin
		case (sel_path)
			2'd1:    pac_sel = sel_alu_src[0] ? fwd[0] : '0;
			2'd2:    pac_sel = sel_alu_src[1] ? fwd[1] : '0;
			2'd3:    pac_sel = sel_alu_src[2] ? fwd[2] : '0;
			default: pac_sel = '0;
		endcase
	end

	always_comb begin
		case (sel_path_wb)
			2'd2:    wb_src_sel = fwd[1];
			2'd3:    wb_src_sel = fwd[2];
			default: wb_src_sel = fwd[0];
		endcase
	end

	////////////////////////////////////////////////////////////
	// One stage to line up with the ALU result
	always_ff @(posedge clock) begin
		if (ops.req) begin
			pac_q    <= pac_sel;
			wb_src_q <= wb_src_sel;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			use_src_q <= 1'b0;
		end else if (ops.req) begin
			use_src_q <= (sel_path_wb != 2'd0);
		end
	end

	assign pac_data    = pac_q;
	assign wb_sel_data = use_src_q ? wb_src_q : wb_data;

endmodule

// ==== rtl/operand_if.sv ====
// Operand bundle between register read and routing network
`timescale 1ns/1ps

interface operand_if
	import lane_pkg::*;
();

	logic   req;         // Operand words below are valid
	index_t idx1;        // Register index of each source
	index_t idx2;
	index_t idx3;
	data_t  src1;        // Registered read data
	data_t  src2;
	data_t  src3;

	// Register read side
	modport reader (
		output req, idx1, idx2, idx3, src1, src2, src3
	);

	// Routing network side
	modport network (
		input req, idx1, idx2, idx3, src1, src2, src3
	);

endinterface

// ==== rtl/slice_counter.sv ====
// Element index counter with last-element flag
`timescale 1ns/1ps

module slice_counter
	import lane_pkg::*;
`include "lane_params.svh"
(
	input  logic   clock,
	input  logic   arst_n,
	input  logic   clr,
	input  logic   en,
	input  index_t slice_len,
	output index_t index,
	output logic   last
);

	index_t len_eff;

	// Longer slices are cut at the lane limit
	assign len_eff = (slice_len > index_t'(`LANE_SLICE_MAX)) ? index_t'(`LANE_SLICE_MAX) : slice_len;
	assign last    = (index == len_eff - 1'b1);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			index <= '0;
		end else if (clr) begin
			index <= '0;
		end else if (en && !last) begin
			index <= index + 1'b1;        // Holds on stall and at the end
		end
	end

endmodule

// ==== sim/lane_patterns.hex ====
// tag 1 load: index data 0 / tag 2 instr: ctrl{op,path,path_wb,alu_src,burst} {dst,s1,s2,s3} len
// tag 3 expect: wb_index wb_data pac_data / tag 0 end of records
1 00 00000001 0
1 01 00000002 0
1 02 00000003 0
1 03 00000004 0
1 04 00000005 0
1 05 00000006 0
1 06 00000007 0
1 07 00000008 0
1 08 00000010 0
1 09 00000020 0
1 0a 00000030 0
1 0b 00000040 0
1 0c 00000050 0
1 0d 00000060 0
1 0e 00000070 0
1 0f 00000080 0
// ADD, PAC takes source 1
2 01010 20000800 3
3 20 00000011 00000001
3 21 00000022 00000002
3 22 00000033 00000003
// SUB, path and ALU select disagree
2 12010 23080000 1
3 23 0000000f 00000000
// MAC over eight elements, PAC takes source 3
2 23040 28000800 8
3 28 00000011 00000001
3 29 00000042 00000002
3 2a 00000093 00000003
3 2b 00000104 00000004
3 2c 00000195 00000005
3 2d 00000246 00000006
3 2e 00000317 00000007
3 2f 00000408 00000008
// Sources are earlier destinations
2 00000 30202d00 3
3 30 00000257 00000000
3 31 00000339 00000000
3 32 0000043b 00000000
2 12020 33313000 2
3 33 000000e2 00000257
3 34 00000102 00000339
// MAC with a load burst, buffer fills and issue stalls
2 21071 38080028 6
3 38 00000021 00000010
3 39 00000082 00000020
3 3a 00000123 00000030
3 3b 00000204 00000040
3 3c 00000325 00000050
3 3d 00000486 00000060
// Writeback taken from source 2, 3, then 1
2 00200 24003808 2
3 24 00000021 00000000
3 25 00000082 00000000
2 03340 2600003d 1
3 26 00000486 00000486
2 01110 27240000 1
3 27 00000021 00000021
// Reads back the source-path results
2 02020 10240000 4
3 10 00000022 00000001
3 11 00000084 00000002
3 12 00000489 00000003
3 13 00000025 00000004
0 0 0 0

// ==== sim/lane_properties.sv ====
// Lane top assertions, bound to lane_top
// Reset values, done pulse width, busy and done pairing
`timescale 1ns/1ps

module lane_properties (
	input logic clock,
	input logic arst_n,
	input logic busy,
	input logic done,
	input logic wb_valid,
	input logic buff_full
);

	// Buffer empty and no writeback right out of reset
	reset_low_a : assert property (@(posedge clock) $rose(arst_n) |-> !buff_full && !wb_valid)
		else $error("buff_full or wb_valid high after reset");

	done_pulse_a : assert property (@(posedge clock) disable iff (!arst_n) done |=> !done)
		else $error("done held longer than one cycle");

	busy_fall_a : assert property (@(posedge clock) disable iff (!arst_n) $fell(busy) |-> done)
		else $error("busy dropped without done");

endmodule

bind lane_top lane_properties props_i (
	.clock     (clock),
	.arst_n    (arst_n),
	.busy      (busy),
	.done      (done),
	.wb_valid  (wb_valid),
	.buff_full (buff_full)
);

// ==== sim/tb_lane.sv ====
// Lane testbench
// Pattern file loads and instructions, writeback and PAC checks
`timescale 1ns/1ps

module tb_lane
	import lane_pkg::*;
();

	localparam int PAT_WORDS    = 512;      // Four words per record
	localparam int DONE_TIMEOUT = 200;      // Cycles from start to done
	localparam int BURST_CYCLES = 12;       // Long enough to fill the buffer

	logic       clock = 1'b0;
	logic       arst_n;
	logic       start;
	alu_op_t    op;
	index_t     dst;
	index_t     src1_base;
	index_t     src2_base;
	index_t     src3_base;
	index_t     slice_len;
	sel_path_t  sel_path;
	sel_path_t  sel_path_wb;
	logic [2:0] sel_alu_src;
	logic       ld_valid;
	index_t     ld_index;
	data_t      ld_data;
	logic       busy;
	logic       done;
	logic       wb_valid;
	index_t     wb_index;
	data_t      wb_data;
	data_t      pac_data;
	logic       buff_full;

	logic [31:0] pat [PAT_WORDS];       // Raw pattern words
	index_t      exp_idx [$];           // Expected writebacks of current instruction
	data_t       exp_data [$];
	data_t       exp_pac [$];
	int          mismatch_cnt;
	int          fail_cnt;
	int          wb_count;              // Writebacks seen since start
	logic        full_seen;
	integer      seed;
	int          ptr;
	int          q;
	logic        parse_on;

	always #50 clock = ~clock;          // 100 ns period

	lane_top dut_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.start       (start),
		.op          (op),
		.dst         (dst),
		.src1_base   (src1_base),
		.src2_base   (src2_base),
		.src3_base   (src3_base),
		.slice_len   (slice_len),
		.sel_path    (sel_path),
		.sel_path_wb (sel_path_wb),
		.sel_alu_src (sel_alu_src),
		.ld_valid    (ld_valid),
		.ld_index    (ld_index),
		.ld_data     (ld_data),
		.busy        (busy),
		.done        (done),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (wb_data),
		.pac_data    (pac_data),
		.buff_full   (buff_full)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	task automatic wait_done();
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && (n < DONE_TIMEOUT)) begin
			@(negedge clock);
			seen = done;
			n++;
			check_val("busy", busy, seen ? 32'd0 : 32'd1);   // Falls together with done
		end
		if (!seen) begin
			fail_cnt++;
			$display("timeout: no done pulse within %0d cycles", DONE_TIMEOUT);
			finish_run();
		end
	endtask

	// One load with a random gap in front
	task automatic load_reg(input index_t idx, input data_t data);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(negedge clock);
		ld_valid = 1'b1;
		ld_index = idx;
		ld_data  = data;
		@(negedge clock);
		ld_valid = 1'b0;
	endtask

	// Load port held busy so the buffer cannot drain
	task automatic load_burst();
		repeat (BURST_CYCLES) begin
			ld_valid = 1'b1;
			ld_index = 6'd63;                // Scratch register that nothing reads
			ld_data  = 32'h5A5A_5A5A;
			@(negedge clock);
		end
		ld_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Instruction run with fields held until done
	task automatic run_instr(input logic [31:0] ctrl, input logic [31:0] regs,
		input logic [31:0] len);
		op          = alu_op_t'(ctrl[17:16]);
		sel_path    = ctrl[13:12];
		sel_path_wb = ctrl[9:8];
		sel_alu_src = ctrl[6:4];
		dst         = regs[29:24];
		src1_base   = regs[21:16];
		src2_base   = regs[13:8];
		src3_base   = regs[5:0];
		slice_len   = len[5:0];
		wb_count    = 0;
		full_seen   = 1'b0;
		start       = 1'b1;
		fork
			begin
				@(negedge clock);
				start = 1'b0;
				wait_done();
			end
			begin
				if (ctrl[0]) begin
					load_burst();
				end
			end
		join
		check_val("wb_count", wb_count, len);           // L pulses before done
		if (ctrl[0] && !full_seen) begin
			fail_cnt++;
			$display("buff_full never rose during the load burst");
		end
		if (exp_idx.size() != 0) begin
			fail_cnt++;
			$display("%0d expected writebacks never arrived", exp_idx.size());
			exp_idx.delete();
			exp_data.delete();
			exp_pac.delete();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Writeback monitor
	always @(negedge clock) begin
		if (arst_n && buff_full) begin
			full_seen = 1'b1;
		end
		if (arst_n && wb_valid) begin
			wb_count++;
			if (exp_idx.size() == 0) begin
				fail_cnt++;
				$display("writeback to index %h with no expected record left", wb_index);
			end else begin
				check_val("wb_index", wb_index, exp_idx.pop_front());
				check_val("wb_data", wb_data, exp_data.pop_front());
				check_val("pac_data", pac_data, exp_pac.pop_front());
			end
		end
	end

	initial begin
		arst_n       = 1'b0;
		start        = 1'b0;
		op           = ADD;
		dst          = '0;
		src1_base    = '0;
		src2_base    = '0;
		src3_base    = '0;
		slice_len    = '0;
		sel_path     = '0;
		sel_path_wb  = '0;
		sel_alu_src  = '0;
		ld_valid     = 1'b0;
		ld_index     = '0;
		ld_data      = '0;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		wb_count     = 0;
		full_seen    = 1'b0;
		seed         = 32'h6295_78de;
		$readmemh("sim/lane_patterns.hex", pat);
		repeat (10) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		ptr      = 0;
		parse_on = 1'b1;
		while (parse_on && (ptr + 3 < PAT_WORDS)) begin
			case (pat[ptr])
				32'd1: begin
					load_reg(pat[ptr+1][5:0], pat[ptr+2]);
					ptr += 4;
				end
				32'd2: begin
					q = ptr + 4;                            // Gather its expected records
					while ((q + 3 < PAT_WORDS) && (pat[q] == 32'd3)) begin
						exp_idx.push_back(pat[q+1][5:0]);
						exp_data.push_back(pat[q+2]);
						exp_pac.push_back(pat[q+3]);
						q += 4;
					end
					run_instr(pat[ptr+1], pat[ptr+2], pat[ptr+3]);
					ptr = q;
				end
				32'd0: parse_on = 1'b0;                     // End record
				default: begin
					fail_cnt++;
					$display("bad record tag %h at pattern word %0d", pat[ptr], ptr);
					parse_on = 1'b0;
				end
			endcase
		end
		repeat (4) @(negedge clock);
		finish_run();
	end

endmodule
